//--- include/vec_defs.svh
`ifndef VEC_DEFS_SVH
`define VEC_DEFS_SVH

// Command intake
`define ISSUE_LANE 4
`define CQ_DEPTH 8

// Vector register file geometry
`define VLEN 128
`define NUM_VREG 32
`define VREG_IDX_W 5

// funct6 encodings of the supported OPIVV/OPIVX instructions
`define FUNCT6_VADD 6'b000000
`define FUNCT6_VSUB 6'b000010
`define FUNCT6_VMUL 6'b100101

// Operand forms
`define FUNCT3_OPIVV 3'b000
`define FUNCT3_OPIVX 3'b100

`define MUL_STAGES 3

`endif

//--- src/vec_pkg.sv
`include "vec_defs.svh"

package vec_pkg;

    // Element width as programmed in vtype
    typedef enum logic {
        SEW8  = 1'b0,
        SEW16 = 1'b1
    } sew_e;

    // One command from the scalar core
    typedef struct packed {
        logic [31:0] insn;
        logic [31:0] scalar;
        sew_e        sew;
    } rvv_cmd_t;

    // A register word seen as bytes or as halfwords
    typedef union packed {
        logic [`VLEN/8-1:0][7:0]   b;
        logic [`VLEN/16-1:0][15:0] h;
    } vreg_data_u;

    // Operation sent to the ALU or the multiplier
    typedef struct packed {
        logic [5:0]            funct6;
        sew_e                  sew;
        logic [`VREG_IDX_W-1:0] vd;
        vreg_data_u            opa;
        // Already broadcast for the .vx forms
        vreg_data_u            opb;
    } exec_uop_t;

    // Register write request
    typedef struct packed {
        logic [`VREG_IDX_W-1:0] vd;
        vreg_data_u            data;
    } wb_req_t;

endpackage

//--- src/cmd_queue.sv
`include "vec_defs.svh"

module cmd_queue
    import vec_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic     [`ISSUE_LANE-1:0]     push_valid,
    input  rvv_cmd_t [`ISSUE_LANE-1:0]     push_cmd,
    output logic     [`ISSUE_LANE-1:0]     push_ready,
    input  logic                           pop,
    output rvv_cmd_t                       head,
    output logic                           empty
);

    localparam int PTR_W = $clog2(`CQ_DEPTH);
    localparam int CNT_W = $clog2(`CQ_DEPTH + 1);

    rvv_cmd_t               mem [`CQ_DEPTH];
    logic [PTR_W-1:0]       wptr;
    logic [PTR_W-1:0]       rptr;
    logic [CNT_W-1:0]       count;
    logic [CNT_W-1:0]       free_slots;
    logic [CNT_W-1:0]       n_push;
    logic [`ISSUE_LANE-1:0] accepted;

    function automatic logic [PTR_W-1:0] ptr_add(input logic [PTR_W-1:0] p,
                                                  input int unsigned n);
        int unsigned s;
        s = p + n;
        if (s >= `CQ_DEPTH) begin
            s = s - `CQ_DEPTH;
        end
        return PTR_W'(s);
    endfunction

    assign free_slots = CNT_W'(`CQ_DEPTH) - count;

    // Lane k needs k+1 free entries
    always_comb begin
        for (int k = 0; k < `ISSUE_LANE; k++) begin
            push_ready[k] = (free_slots > k);
        end
    end

    assign accepted = push_valid & push_ready;

    // Length of the accepted run starting at lane 0
    always_comb begin
        n_push = '0;
        for (int k = 0; k < `ISSUE_LANE; k++) begin
            if (accepted[k] && n_push == k) begin
                n_push = CNT_W'(k + 1);
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < `ISSUE_LANE; k++) begin
            if (k < n_push) begin
                mem[ptr_add(wptr, k)] <= push_cmd[k];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            wptr  <= ptr_add(wptr, n_push);
            if (pop) begin
                rptr <= ptr_add(rptr, 1);
            end
            count <= count + n_push - CNT_W'(pop);
        end
    end

    assign head  = mem[rptr];
    assign empty = (count == '0);

    // Source must present its valids as a run from lane 0
    a_push_contiguous: assert property (@(posedge clk) disable iff (!rst_n)
        ((accepted + 1'b1) & accepted) == '0)
        else $error("command queue push pattern not contiguous: %b", $sampled(accepted));

    a_pop_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> !empty)
        else $error("command queue popped while empty");

endmodule

//--- src/vec_decode.sv
`include "vec_defs.svh"

module vec_decode
    import vec_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  rvv_cmd_t                head,
    input  logic                    empty,
    output logic                    pop,
    output logic [`VREG_IDX_W-1:0]  rd_idx_a,
    output logic [`VREG_IDX_W-1:0]  rd_idx_b,
    input  vreg_data_u              rd_data_a,
    input  vreg_data_u              rd_data_b,
    input  logic                    alu_busy,
    output logic                    alu_issue,
    output logic                    mul_issue,
    output exec_uop_t               uop,
    input  logic                    wb_valid,
    input  wb_req_t                 wb
);

    logic [5:0]             funct6;
    logic [2:0]             funct3;
    logic [`VREG_IDX_W-1:0] vs2;
    logic [`VREG_IDX_W-1:0] vs1;
    logic [`VREG_IDX_W-1:0] vd;
    logic                   is_vx;
    logic                   is_alu_op;
    logic                   is_mul_op;
    logic                   is_known;
    logic                   hazard;
    logic [`NUM_VREG-1:0]   busy;

    // OP-V field split
    assign funct6 = head.insn[31:26];
    assign vs2    = head.insn[24:20];
    assign vs1    = head.insn[19:15];
    assign funct3 = head.insn[14:12];
    assign vd     = head.insn[11:7];

    assign is_vx     = (funct3 == `FUNCT3_OPIVX);
    assign is_alu_op = (funct6 == `FUNCT6_VADD) || (funct6 == `FUNCT6_VSUB);
    assign is_mul_op = (funct6 == `FUNCT6_VMUL);
    assign is_known  = (is_vx || funct3 == `FUNCT3_OPIVV) && (is_alu_op || is_mul_op);

    assign rd_idx_a = vs2;
    assign rd_idx_b = vs1;

    // RAW on sources, WAW on the destination; vs1 is a scalar slot for .vx
    assign hazard = busy[vs2] || busy[vd] || (!is_vx && busy[vs1]);

    // Unknown encodings are popped without issue
    always_comb begin
        pop = 1'b0;
        if (!empty) begin
            if (!is_known) begin
                pop = 1'b1;
            end else if (!hazard) begin
                pop = is_mul_op || !alu_busy;
            end
        end
    end

    assign alu_issue = pop && is_known && is_alu_op;
    assign mul_issue = pop && is_known && is_mul_op;

    always_comb begin
        uop.funct6 = funct6;
        uop.sew    = head.sew;
        uop.vd     = vd;
        uop.opa    = rd_data_a;
        if (!is_vx) begin
            uop.opb = rd_data_b;
        end else if (head.sew == SEW16) begin
            for (int i = 0; i < `VLEN / 16; i++) begin
                uop.opb.h[i] = head.scalar[15:0];
            end
        end else begin
            for (int i = 0; i < `VLEN / 8; i++) begin
                uop.opb.b[i] = head.scalar[7:0];
            end
        end
    end

    // Scoreboard; a write and an issue never hit the same register in one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= '0;
        end else begin
            if (wb_valid) begin
                busy[wb.vd] <= 1'b0;
            end
            if (alu_issue || mul_issue) begin
                busy[vd] <= 1'b1;
            end
        end
    end

    // Every write must belong to an issued, still outstanding operation
    a_wb_to_busy: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> busy[wb.vd])
        else $error("write to register v%0d that is not busy", $sampled(wb.vd));

endmodule

//--- src/vec_alu.sv
`include "vec_defs.svh"

module vec_alu
    import vec_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      issue,
    input  exec_uop_t uop,
    output logic      req,
    output wb_req_t   req_data,
    input  logic      gnt,
    output logic      busy
);

    logic       is_sub;
    vreg_data_u result;
    logic       res_valid;
    wb_req_t    res;

    assign is_sub = (uop.funct6 == `FUNCT6_VSUB);

    // vd = vs2 +/- vs1, wrapping per element
    always_comb begin
        if (uop.sew == SEW16) begin
            for (int i = 0; i < `VLEN / 16; i++) begin
                result.h[i] = is_sub ? uop.opa.h[i] - uop.opb.h[i]
                                     : uop.opa.h[i] + uop.opb.h[i];
            end
        end else begin
            for (int i = 0; i < `VLEN / 8; i++) begin
                result.b[i] = is_sub ? uop.opa.b[i] - uop.opb.b[i]
                                     : uop.opa.b[i] + uop.opb.b[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else if (issue) begin
            res_valid <= 1'b1;
        end else if (gnt) begin
            res_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            res.vd   <= uop.vd;
            res.data <= result;
        end
    end

    assign req      = res_valid;
    assign req_data = res;
    // Held result blocks the next ALU issue
    assign busy     = res_valid && !gnt;

endmodule

//--- src/vec_mul.sv
`include "vec_defs.svh"

module vec_mul
    import vec_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      issue,
    input  exec_uop_t uop,
    output logic      req,
    output wb_req_t   req_data
);

    // Stage 0 holds operands
    logic                    s0_valid;
    exec_uop_t               s0_uop;
    vreg_data_u              prod;

    // Stages 1 and up hold products
    logic    [`MUL_STAGES-1:1] pv;
    wb_req_t                   pd [`MUL_STAGES-1:1];

    // Low sew bits of each element product
    always_comb begin
        if (s0_uop.sew == SEW16) begin
            for (int i = 0; i < `VLEN / 16; i++) begin
                prod.h[i] = s0_uop.opa.h[i] * s0_uop.opb.h[i];
            end
        end else begin
            for (int i = 0; i < `VLEN / 8; i++) begin
                prod.b[i] = s0_uop.opa.b[i] * s0_uop.opb.b[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s0_valid <= 1'b0;
            pv       <= '0;
        end else begin
            s0_valid <= issue;
            pv       <= {pv[`MUL_STAGES-2:1], s0_valid};
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            s0_uop <= uop;
        end
        pd[1].vd   <= s0_uop.vd;
        pd[1].data <= prod;
        for (int k = 2; k < `MUL_STAGES; k++) begin
            pd[k] <= pd[k-1];
        end
    end

    // Never stalls, so the request lands MUL_STAGES cycles after issue
    assign req      = pv[`MUL_STAGES-1];
    assign req_data = pd[`MUL_STAGES-1];

endmodule

//--- src/wb_arbiter.sv
`include "vec_defs.svh"

module wb_arbiter
    import vec_pkg::*;
(
    input  logic    alu_req,
    input  logic    mul_req,
    input  wb_req_t alu_data,
    input  wb_req_t mul_data,
    output logic    alu_gnt,
    output logic    wb_valid,
    output wb_req_t wb
);

    logic mul_gnt;

    // Multiplier has no stall path so it always wins
    assign mul_gnt  = mul_req;
    assign alu_gnt  = alu_req && !mul_req;
    assign wb_valid = mul_gnt || alu_gnt;

    always_comb begin
        if (mul_gnt) begin
            wb = mul_data;
        end else begin
            wb = alu_data;
        end
    end

endmodule

//--- src/vec_regfile.sv
`include "vec_defs.svh"

module vec_regfile
    import vec_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`VREG_IDX_W-1:0] rd_idx_a,
    input  logic [`VREG_IDX_W-1:0] rd_idx_b,
    output vreg_data_u             rd_data_a,
    output vreg_data_u             rd_data_b,
    input  logic                   wb_valid,
    input  wb_req_t                wb
);

    vreg_data_u regs [`NUM_VREG];

    // Architectural state starts at zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_VREG; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid) begin
            regs[wb.vd] <= wb.data;
        end
    end

    // Reads see the old value during a same-cycle write
    assign rd_data_a = regs[rd_idx_a];
    assign rd_data_b = regs[rd_idx_b];

endmodule

//--- src/vec_backend.sv
`include "vec_defs.svh"

module vec_backend (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic              [`ISSUE_LANE-1:0]  cmd_valid,
    input  vec_pkg::rvv_cmd_t [`ISSUE_LANE-1:0]  cmds,
    output logic              [`ISSUE_LANE-1:0]  cmd_ready,
    output logic                                 retire_valid,
    output vec_pkg::wb_req_t                     retire
);

    // Queue to decode
    vec_pkg::rvv_cmd_t      cq_head;
    logic                   cq_empty;
    logic                   cq_pop;

    // Operand reads
    logic [`VREG_IDX_W-1:0] rd_idx_a;
    logic [`VREG_IDX_W-1:0] rd_idx_b;
    vec_pkg::vreg_data_u    rd_data_a;
    vec_pkg::vreg_data_u    rd_data_b;

    // Issue and writeback
    logic                   alu_busy;
    logic                   alu_issue;
    logic                   mul_issue;
    vec_pkg::exec_uop_t     issue_uop;
    logic                   alu_req;
    logic                   alu_gnt;
    vec_pkg::wb_req_t       alu_req_data;
    logic                   mul_req;
    vec_pkg::wb_req_t       mul_req_data;

    cmd_queue u_cmd_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .push_valid (cmd_valid),
        .push_cmd   (cmds),
        .push_ready (cmd_ready),
        .pop        (cq_pop),
        .head       (cq_head),
        .empty      (cq_empty)
    );

    vec_decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .head      (cq_head),
        .empty     (cq_empty),
        .pop       (cq_pop),
        .rd_idx_a  (rd_idx_a),
        .rd_idx_b  (rd_idx_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .alu_busy  (alu_busy),
        .alu_issue (alu_issue),
        .mul_issue (mul_issue),
        .uop       (issue_uop),
        .wb_valid  (retire_valid),
        .wb        (retire)
    );

    vec_alu u_alu (
        .clk      (clk),
        .rst_n    (rst_n),
        .issue    (alu_issue),
        .uop      (issue_uop),
        .req      (alu_req),
        .req_data (alu_req_data),
        .gnt      (alu_gnt),
        .busy     (alu_busy)
    );

    vec_mul u_mul (
        .clk      (clk),
        .rst_n    (rst_n),
        .issue    (mul_issue),
        .uop      (issue_uop),
        .req      (mul_req),
        .req_data (mul_req_data)
    );

    // The granted write is also the retire strobe
    wb_arbiter u_wb_arbiter (
        .alu_req  (alu_req),
        .mul_req  (mul_req),
        .alu_data (alu_req_data),
        .mul_data (mul_req_data),
        .alu_gnt  (alu_gnt),
        .wb_valid (retire_valid),
        .wb       (retire)
    );

    vec_regfile u_vrf (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_idx_a  (rd_idx_a),
        .rd_idx_b  (rd_idx_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .wb_valid  (retire_valid),
        .wb        (retire)
    );

endmodule

//--- verif/tb_vec_backend.sv
`include "vec_defs.svh"

module tb_vec_backend
    import vec_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int EXP_SLOTS  = 16;
    // Cycle budget per test
    localparam int LEN_RESET  = 8;
    localparam int LEN_MIXED  = 300;
    localparam int LEN_CHAIN  = 100;
    localparam int LEN_B2B    = 60;
    localparam int LEN_BURST  = 200;
    localparam int MAX_CYCLES = (LEN_RESET + LEN_MIXED + LEN_CHAIN + LEN_B2B + LEN_BURST) * 4;

    logic                               clk;
    logic                               rst_n;
    logic     [`ISSUE_LANE-1:0]         cmd_valid;
    rvv_cmd_t [`ISSUE_LANE-1:0]         cmds;
    logic     [`ISSUE_LANE-1:0]         cmd_ready;
    logic                               retire_valid;
    wb_req_t                            retire;

    // Reference model state
    logic [31:0]      lcg_state;
    logic [`VLEN-1:0] model_regs [`NUM_VREG];
    logic [`VLEN-1:0] exp_mem [`NUM_VREG][EXP_SLOTS];
    int               exp_wr [`NUM_VREG];
    int               exp_rd [`NUM_VREG];
    int               issued;
    int               retired;
    int               errors;
    int               err_mark;
    int               tests_ok;
    int               tests_bad;
    int               cycles;
    int               occ;
    logic             saw_full;
    logic             exp_some;
    logic [`VLEN-1:0] exp_now;
    rvv_cmd_t         pend [$];

    vec_backend dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_valid    (cmd_valid),
        .cmds         (cmds),
        .cmd_ready    (cmd_ready),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] rand_word();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [4:0] pick_reg(input int lo, input int n);
        return 5'(lo + int'(rand_word() >> 16) % n);
    endfunction

    function automatic rvv_cmd_t make_cmd(input logic [5:0] f6, input logic [2:0] f3,
                                          input logic [4:0] vd, input logic [4:0] vs2,
                                          input logic [4:0] vs1, input logic [31:0] scalar,
                                          input sew_e sew);
        rvv_cmd_t c;
        c.insn   = {f6, 1'b1, vs2, vs1, f3, vd, 7'b1010111};
        c.scalar = scalar;
        c.sew    = sew;
        return c;
    endfunction

    function automatic rvv_cmd_t rand_cmd(input int lo, input int n);
        logic [5:0] f6;
        logic [2:0] f3;
        case (int'(rand_word() >> 20) % 3)
            0:       f6 = `FUNCT6_VADD;
            1:       f6 = `FUNCT6_VSUB;
            default: f6 = `FUNCT6_VMUL;
        endcase
        f3 = ((rand_word() >> 27) & 32'd1) != 0 ? `FUNCT3_OPIVX : `FUNCT3_OPIVV;
        return make_cmd(f6, f3, pick_reg(lo, n), pick_reg(lo, n), pick_reg(lo, n),
                        rand_word(), sew_e'(rand_word() >> 31));
    endfunction

    function automatic int lane_count(input logic [`ISSUE_LANE-1:0] m);
        int n;
        n = 0;
        for (int k = 0; k < `ISSUE_LANE; k++) begin
            n += int'(m[k]);
        end
        return n;
    endfunction

    // Element-wise result from the register model, queued for vd
    task automatic model_apply(input rvv_cmd_t c);
        logic [4:0]       vd;
        logic [`VLEN-1:0] a;
        logic [`VLEN-1:0] b;
        logic [`VLEN-1:0] r;
        logic [15:0]      mask;
        logic [15:0]      x;
        logic [15:0]      y;
        logic [15:0]      z;
        int               w;
        vd   = c.insn[11:7];
        a    = model_regs[c.insn[24:20]];
        b    = model_regs[c.insn[19:15]];
        w    = (c.sew == SEW16) ? 16 : 8;
        mask = (c.sew == SEW16) ? 16'hffff : 16'h00ff;
        r    = '0;
        for (int i = 0; i < `VLEN / w; i++) begin
            x = 16'(a >> (w * i)) & mask;
            if (c.insn[14:12] == `FUNCT3_OPIVX) begin
                y = c.scalar[15:0] & mask;
            end else begin
                y = 16'(b >> (w * i)) & mask;
            end
            case (c.insn[31:26])
                `FUNCT6_VSUB: z = x - y;
                `FUNCT6_VMUL: z = x * y;
                default:      z = x + y;
            endcase
            r = r | (`VLEN'(z & mask) << (w * i));
        end
        model_regs[vd] = r;
        if (exp_wr[vd] - exp_rd[vd] >= EXP_SLOTS) begin
            errors++;
            $display("expected-result store for v%0d overflowed", vd);
        end
        exp_mem[vd][exp_wr[vd] % EXP_SLOTS] = r;
        exp_wr[vd]++;
        issued++;
    endtask

    // Valid lanes stay up until ready; accepted lanes go into the model in order
    task automatic drive_pending(input int max_lanes, input logic rand_lanes);
        int want;
        int took;
        while (pend.size() > 0) begin
            @(negedge clk);
            want = rand_lanes ? int'(rand_word() >> 24) % max_lanes + 1 : max_lanes;
            if (want > pend.size()) begin
                want = pend.size();
            end
            cmd_valid = '0;
            took      = 0;
            for (int k = 0; k < want; k++) begin
                cmd_valid[k] = 1'b1;
                cmds[k]      = pend[k];
                if (cmd_ready[k] && took == k) begin
                    took = k + 1;
                end
            end
            for (int k = 0; k < took; k++) begin
                model_apply(pend.pop_front());
            end
        end
        @(negedge clk);
        cmd_valid = '0;
    endtask

    task automatic wait_drain();
        while (issued != retired) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    task automatic close_test(input string name);
        if (errors == err_mark) begin
            tests_ok++;
            $display("%s: ok", name);
        end else begin
            tests_bad++;
            $display("%s: %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    // Oldest expected entry for the register being retired
    assign exp_some = (exp_wr[retire.vd] != exp_rd[retire.vd]);
    assign exp_now  = exp_mem[retire.vd][exp_rd[retire.vd] % EXP_SLOTS];

    always @(posedge clk) begin
        if (rst_n && retire_valid && exp_some) begin
            exp_rd[retire.vd] = exp_rd[retire.vd] + 1;
            retired++;
        end
    end

    // Queue occupancy from accepted lanes and decode pops
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            occ      <= 0;
            saw_full <= 1'b0;
        end else begin
            occ <= occ + lane_count(cmd_valid & cmd_ready) - int'(dut_i.cq_pop);
            if (occ == `CQ_DEPTH) begin
                saw_full <= 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles", cycles);
            $display("test failed");
            $finish;
        end
    end

    a_reset_ready: assert property (@(posedge clk) $rose(rst_n) |-> cmd_ready == '1)
        else begin
            errors++;
            $display("Fail t=%0t cmd_ready: got %b, expected 1111", $time, $sampled(cmd_ready));
        end

    a_reset_retire: assert property (@(posedge clk) $rose(rst_n) |-> !retire_valid)
        else begin
            errors++;
            $display("Fail t=%0t retire_valid: got %b, expected 0", $time,
                     $sampled(retire_valid));
        end

    a_retire_known: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid |-> exp_some)
        else begin
            errors++;
            $display("retire to v%0d with no command outstanding", $sampled(retire.vd));
        end

    a_retire_value: assert property (@(posedge clk) disable iff (!rst_n)
        (retire_valid && exp_some) |-> retire.data == exp_now)
        else begin
            errors++;
            $display("Fail t=%0t retire.data v%0d: got %h, expected %h", $time,
                     $sampled(retire.vd), $sampled(retire.data), $sampled(exp_now));
        end

    // ALU result is due one cycle after issue, multiply result MUL_STAGES cycles after
    a_retire_on_result: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(dut_i.mul_issue, `MUL_STAGES) || $past(dut_i.alu_issue)) |-> retire_valid)
        else begin
            errors++;
            $display("no retire at t=%0t although a unit result was due", $time);
        end

    a_ready_contiguous: assert property (@(posedge clk) disable iff (!rst_n)
        ((cmd_ready + 1'b1) & cmd_ready) == '0)
        else begin
            errors++;
            $display("cmd_ready not a run from lane 0: %b", $sampled(cmd_ready));
        end

    a_ready_full: assert property (@(posedge clk) disable iff (!rst_n)
        occ == `CQ_DEPTH |-> cmd_ready == '0)
        else begin
            errors++;
            $display("Fail t=%0t cmd_ready: got %b, expected 0000", $time, $sampled(cmd_ready));
        end

    initial begin
        logic [4:0] prev;
        clk       = 1'b0;
        rst_n     = 1'b0;
        cmd_valid = '0;
        cmds      = '0;
        lcg_state = 32'ha12f5502;
        issued    = 0;
        retired   = 0;
        errors    = 0;
        err_mark  = 0;
        tests_ok  = 0;
        tests_bad = 0;
        cycles    = 0;
        for (int r = 0; r < `NUM_VREG; r++) begin
            model_regs[r] = '0;
            exp_wr[r]     = 0;
            exp_rd[r]     = 0;
        end
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        repeat (3) @(negedge clk);
        close_test("reset values");

        // Scalar loads from v0, then random ops over v1..v8
        for (int r = 1; r <= 8; r++) begin
            pend.push_back(make_cmd(`FUNCT6_VADD, `FUNCT3_OPIVX, 5'(r), 5'd0, 5'd0,
                                    rand_word(), sew_e'(rand_word() >> 31)));
        end
        for (int i = 0; i < 40; i++) begin
            pend.push_back(rand_cmd(1, 8));
        end
        drive_pending(`ISSUE_LANE, 1'b1);
        wait_drain();
        close_test("mixed ops");

        // Multiply and add alternate, each reading the previous result
        prev = 5'd1;
        for (int i = 0; i < 12; i++) begin
            if (i % 2 == 0) begin
                pend.push_back(make_cmd(`FUNCT6_VMUL, `FUNCT3_OPIVV, 5'(9 + i), prev,
                                        5'(2 + i % 5), 32'd0, sew_e'(rand_word() >> 31)));
            end else begin
                pend.push_back(make_cmd(`FUNCT6_VADD, `FUNCT3_OPIVX, 5'(9 + i), prev,
                                        5'd0, rand_word(), sew_e'(rand_word() >> 31)));
            end
            prev = 5'(9 + i);
        end
        drive_pending(`ISSUE_LANE, 1'b1);
        wait_drain();
        close_test("dependent chain");

        for (int i = 0; i < 16; i++) begin
            pend.push_back(make_cmd((i % 2 == 0) ? `FUNCT6_VADD : `FUNCT6_VMUL,
                                    `FUNCT3_OPIVV, 5'(16 + i), pick_reg(1, 7),
                                    pick_reg(1, 7), 32'd0, sew_e'(rand_word() >> 31)));
        end
        drive_pending(`ISSUE_LANE, 1'b0);
        wait_drain();
        close_test("independent back to back");

        for (int i = 0; i < 32; i++) begin
            pend.push_back(rand_cmd(1, 8));
        end
        drive_pending(`ISSUE_LANE, 1'b0);
        wait_drain();
        if (!saw_full) begin
            errors++;
            $display("command queue never reached full during the bursts");
        end
        close_test("four-lane bursts");

        for (int r = 0; r < `NUM_VREG; r++) begin
            if (exp_wr[r] != exp_rd[r]) begin
                errors++;
                $display("v%0d has %0d expected results left over", r, exp_wr[r] - exp_rd[r]);
            end
        end
        $display("tests run: %0d, passed: %0d, failed: %0d",
                 tests_ok + tests_bad, tests_ok, tests_bad);
        if (errors == 0 && tests_bad == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+include
src/vec_pkg.sv
src/cmd_queue.sv
src/vec_decode.sv
src/vec_alu.sv
src/vec_mul.sv
src/wb_arbiter.sv
src/vec_regfile.sv
src/vec_backend.sv
verif/tb_vec_backend.sv
